/* dv/spi_cmd_props.sv */
`timescale 1ns/1ps

module spi_cmd_props #(
   parameter int VEC_LEN = 4
) (
   input logic                 clk,
   input logic                 arst_n,
   input logic                 rx_valid,
   input logic                 tx_load,
   input logic [7:0]           vec_cnt,
   input spi_cmd_pkg::reg_wr_t wr
);

   logic any_wr;

   assign any_wr = wr.wr_inv | wr.wr_leds | wr.wr_vec | wr.init;

   // a response load only follows a received word by one cycle
   load_after_rx: assert property (@(posedge clk) disable iff (!arst_n)
      tx_load |-> $past(rx_valid))
      else $error("tx_load without rx_valid in the previous cycle");

   // strobe is a single cycle
   rx_single: assert property (@(posedge clk) disable iff (!arst_n)
      rx_valid |=> !rx_valid)
      else $error("rx_valid held high for two cycles");

   // vector count stays within the vector length
   cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
      vec_cnt <= 8'(VEC_LEN))
      else $error("vector count above vector length");

   // no register write during reset
   no_wr_in_reset: assert property (@(posedge clk)
      !arst_n |-> !any_wr)
      else $error("register write strobe active during reset");

endmodule

bind cmd_engine spi_cmd_props #(
   .VEC_LEN (VEC_LEN)
) u_props (
   .clk      (clk),
   .arst_n   (arst_n),
   .rx_valid (rx_valid),
   .tx_load  (tx_load),
   .vec_cnt  (vec_cnt),
   .wr       (wr)
);

/* dv/spi_cmd_tb.sv */
`timescale 1ns/1ps

module spi_cmd_tb;

   localparam int VEC_LEN    = 4;
   localparam int W          = spi_cmd_pkg::WORD_BITS;
   localparam int HALF_SCK   = 4;
   localparam int GAP        = 8;
   localparam int RX_TIMEOUT = 12;

   logic       clk;
   logic       arst_n;
   logic       sck;
   logic       ss_n;
   logic       mosi;
   logic       miso;
   logic [2:0] leds;

   integer seed;

   // reference model state
   logic [15:0]  inv_m;
   logic [2:0]   leds_m;
   logic [23:0]  vec_m [VEC_LEN];
   logic [W-1:0] resp_m;
   // 0 idle, 1 vector write, 2 vector read
   int           vec_mode;
   int           vec_idx;

   spi_cmd_top #(
      .VEC_LEN (VEC_LEN)
   ) uut (
      .clk    (clk),
      .arst_n (arst_n),
      .sck    (sck),
      .ss_n   (ss_n),
      .mosi   (mosi),
      .miso   (miso),
      .leds   (leds)
   );

   always #20 clk = ~clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [W-1:0] exp,
                              input logic [W-1:0] act);
      assert (act === exp)
         else fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
   endtask

   // ends 2 ns after the last edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task automatic wait_rx_valid();
      int  n;
      bit  seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < RX_TIMEOUT) begin
         @(posedge clk);
         #2;
         n++;
         if (uut.rx_valid) begin
            seen = 1'b1;
         end
      end
      if (!seen) begin
         fail_run("timeout: no received word strobe after the last sck rising edge");
      end
   endtask

   // one mode 0 frame msb first with miso sampled just before each rising sck
   task automatic spi_frame(input logic [W-1:0] tx, output logic [W-1:0] rx);
      rx   = '0;
      ss_n = 1'b0;
      mosi = tx[W-1];
      wait_cycles(GAP);
      for (int i = W - 1; i >= 0; i--) begin
         mosi = tx[i];
         wait_cycles(HALF_SCK);
         rx[i] = miso;
         sck   = 1'b1;
         if (i == 0) begin
            wait_rx_valid();
         end
         wait_cycles(HALF_SCK);
         sck = 1'b0;
      end
      wait_cycles(GAP);
      ss_n = 1'b1;
      wait_cycles(GAP);
   endtask

   task automatic clear_model();
      inv_m    = '0;
      leds_m   = '0;
      vec_mode = 0;
      vec_idx  = 0;
      for (int i = 0; i < VEC_LEN; i++) begin
         vec_m[i] = '0;
      end
   endtask

   // apply one received word and set the response expected in the next frame
   task automatic model_update(input logic [W-1:0] word);
      spi_cmd_pkg::cmd_frame_t  c;
      spi_cmd_pkg::data_frame_t d;
      c      = word;
      d      = word;
      resp_m = '0;
      if (vec_mode == 1) begin
         vec_m[vec_idx] = d.value;
         vec_idx++;
         if (vec_idx == VEC_LEN) begin
            vec_mode = 0;
         end
      end else if (vec_mode == 2) begin
         if (c.opcode == spi_cmd_pkg::OP_INIT) begin
            clear_model();
         end else begin
            resp_m = {8'h00, vec_m[vec_idx]};
            vec_idx++;
            if (vec_idx == VEC_LEN) begin
               vec_mode = 0;
            end
         end
      end else begin
         case (c.opcode)
            spi_cmd_pkg::OP_INIT:    clear_model();
            spi_cmd_pkg::OP_WR_INV:  inv_m = c.payload[15:0];
            spi_cmd_pkg::OP_RD_INV:  resp_m = {16'h0000, ~inv_m};
            spi_cmd_pkg::OP_WR_LEDS: leds_m = c.payload[2:0];
            spi_cmd_pkg::OP_RD_LEDS: resp_m = {29'd0, leds_m};
            spi_cmd_pkg::OP_WR_VEC: begin
               vec_mode = 1;
               vec_idx  = 0;
            end
            spi_cmd_pkg::OP_RD_VEC: begin
               resp_m   = {8'h00, vec_m[0]};
               vec_idx  = 1;
               vec_mode = (VEC_LEN > 1) ? 2 : 0;
            end
            default: begin
            end
         endcase
      end
   endtask

   // the frame returns the response predicted from the previous word
   task automatic send(input string name, input logic [W-1:0] word);
      logic [W-1:0] got;
      spi_frame(word, got);
      check_value(name, resp_m, got);
      model_update(word);
      check_value($sformatf("%s leds", name), {29'd0, leds_m}, {29'd0, leds});
   endtask

   function automatic logic [W-1:0] cmd_word(input spi_cmd_pkg::opcode_e op,
                                             input logic [23:0] payload);
      spi_cmd_pkg::cmd_frame_t c;
      c.opcode  = op;
      c.payload = payload;
      return c;
   endfunction

   initial begin
      logic [31:0] r;
      seed   = 32'h0714b501;
      clk    = 1'b0;
      arst_n = 1'b0;
      sck    = 1'b0;
      ss_n   = 1'b1;
      mosi   = 1'b0;
      clear_model();
      resp_m = '0;
      wait_cycles(16);
      arst_n = 1'b1;
      check_value("reset leds", '0, {29'd0, leds});
      check_value("reset miso", '0, {31'd0, miso});
      wait_cycles(4);

      send("first frame", cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));

      // test word and its inverse
      r = $random(seed);
      send("wr_inv", cmd_word(spi_cmd_pkg::OP_WR_INV, r[23:0]));
      send("rd_inv", cmd_word(spi_cmd_pkg::OP_RD_INV, 24'h0));
      send("rd_inv response", cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));

      r = $random(seed);
      send("wr_leds", cmd_word(spi_cmd_pkg::OP_WR_LEDS, r[23:0]));
      check_value("leds port", {29'd0, r[2:0]}, {29'd0, leds});
      send("rd_leds", cmd_word(spi_cmd_pkg::OP_RD_LEDS, 24'h0));
      send("rd_leds response", cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));

      // vector data words carry a random top byte
      send("wr_vec", cmd_word(spi_cmd_pkg::OP_WR_VEC, 24'h0));
      for (int i = 0; i < VEC_LEN; i++) begin
         r = $random(seed);
         send($sformatf("vec data %0d", i), r);
      end
      send("rd_vec", cmd_word(spi_cmd_pkg::OP_RD_VEC, 24'h0));
      for (int i = 0; i < VEC_LEN; i++) begin
         // a write inside the readout is ignored
         if (i == 1 && i < VEC_LEN - 1) begin
            send($sformatf("vec entry %0d", i),
                 cmd_word(spi_cmd_pkg::OP_WR_LEDS, {21'd0, ~leds_m}));
         end else begin
            send($sformatf("vec entry %0d", i), cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));
         end
      end

      send("init", cmd_word(spi_cmd_pkg::OP_INIT, 24'h0));
      check_value("leds after init", '0, {29'd0, leds});
      send("init rd_inv", cmd_word(spi_cmd_pkg::OP_RD_INV, 24'h0));
      send("init rd_inv response", cmd_word(spi_cmd_pkg::OP_RD_LEDS, 24'h0));
      send("init rd_leds response", cmd_word(spi_cmd_pkg::OP_RD_VEC, 24'h0));
      for (int i = 0; i < VEC_LEN; i++) begin
         send($sformatf("init vec entry %0d", i), cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));
      end

      // nop and undefined opcodes leave the registers alone
      r = $random(seed);
      send("wr_inv 2", cmd_word(spi_cmd_pkg::OP_WR_INV, r[23:0]));
      r = $random(seed);
      send("wr_leds 2", cmd_word(spi_cmd_pkg::OP_WR_LEDS, r[23:0]));
      r = $random(seed);
      send("nop payload", cmd_word(spi_cmd_pkg::OP_NOP, r[23:0]));
      send("undefined a5", {8'ha5, r[23:0]});
      send("undefined ff", {8'hff, ~r[23:0]});
      send("undefined 08", {8'h08, r[23:0]});
      send("rd_inv 2", cmd_word(spi_cmd_pkg::OP_RD_INV, 24'h0));
      send("rd_leds 2", cmd_word(spi_cmd_pkg::OP_RD_LEDS, 24'h0));
      send("rd_leds 2 response", cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));

      // init in the middle of a readout
      send("wr_vec 2", cmd_word(spi_cmd_pkg::OP_WR_VEC, 24'h0));
      for (int i = 0; i < VEC_LEN; i++) begin
         r = $random(seed);
         send($sformatf("vec data 2 %0d", i), r);
      end
      send("rd_vec 2", cmd_word(spi_cmd_pkg::OP_RD_VEC, 24'h0));
      send("abort entry 0", cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));
      send("abort init", cmd_word(spi_cmd_pkg::OP_INIT, 24'h0));
      send("after abort", cmd_word(spi_cmd_pkg::OP_RD_LEDS, 24'h0));
      send("after abort leds", cmd_word(spi_cmd_pkg::OP_NOP, 24'h0));

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* filelist.f */
source/spi_cmd_pkg.sv
source/spi_slave.sv
source/cmd_engine.sv
source/cmd_regs.sv
source/spi_cmd_top.sv
dv/spi_cmd_props.sv
dv/spi_cmd_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f filelist.f --top-module spi_cmd_tb -o spi_cmd_sim

out=$(./obj_dir/spi_cmd_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
   exit 0
else
   exit 1
fi

/* source/cmd_engine.sv */
`timescale 1ns/1ps

module cmd_engine #(
   parameter int VEC_LEN = 4
) (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                rx_valid,
   input  spi_cmd_pkg::rx_word_u               rx_word,
   input  spi_cmd_pkg::reg_view_t              view,
   input  logic [23:0]                         vec_rd_data,
   output logic                                tx_load,
   output logic [spi_cmd_pkg::WORD_BITS-1:0]   tx_word,
   output spi_cmd_pkg::reg_wr_t                wr,
   output logic [7:0]                          vec_rd_idx
);

   localparam int W = spi_cmd_pkg::WORD_BITS;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_VEC_WR,
      ST_VEC_RD
   } state_e;

   state_e              state;
   // vector words still to come
   logic [7:0]          vec_cnt;
   logic [7:0]          vec_pos;
   logic [W-1:0]        resp_word;
   spi_cmd_pkg::opcode_e opcode;

   assign opcode  = rx_word.cmd.opcode;
   assign vec_pos = 8'(VEC_LEN) - vec_cnt;

   // entry 0 is read out while the RD_VEC command itself is decoded
   assign vec_rd_idx = (state == ST_IDLE) ? 8'd0 : vec_pos;

   // response for the word being received now
   always_comb begin
      resp_word = '0;
      if (state != ST_IDLE) begin
         resp_word = W'(vec_rd_data);
      end else begin
         case (opcode)
            spi_cmd_pkg::OP_RD_INV:  resp_word = {16'h0000, ~view.inv_word};
            spi_cmd_pkg::OP_RD_LEDS: resp_word = W'(view.leds);
            spi_cmd_pkg::OP_RD_VEC:  resp_word = W'(vec_rd_data);
            default:                 resp_word = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         tx_word <= resp_word;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= ST_IDLE;
         vec_cnt <= '0;
         tx_load <= 1'b0;
         wr      <= '0;
      end else begin
         tx_load <= 1'b0;
         wr      <= '0;
         if (rx_valid) begin
            case (state)
               ST_IDLE: begin
                  case (opcode)
                     spi_cmd_pkg::OP_INIT: begin
                        wr.init <= 1'b1;
                     end
                     spi_cmd_pkg::OP_WR_INV: begin
                        wr.wr_inv <= 1'b1;
                        wr.value  <= rx_word.cmd.payload;
                     end
                     spi_cmd_pkg::OP_WR_LEDS: begin
                        wr.wr_leds <= 1'b1;
                        wr.value   <= rx_word.cmd.payload;
                     end
                     spi_cmd_pkg::OP_RD_INV,
                     spi_cmd_pkg::OP_RD_LEDS: begin
                        tx_load <= 1'b1;
                     end
                     spi_cmd_pkg::OP_WR_VEC: begin
                        state   <= ST_VEC_WR;
                        vec_cnt <= 8'(VEC_LEN);
                     end
                     spi_cmd_pkg::OP_RD_VEC: begin
                        tx_load <= 1'b1;
                        vec_cnt <= 8'(VEC_LEN - 1);
                        if (VEC_LEN > 1) begin
                           state <= ST_VEC_RD;
                        end
                     end
                     default: begin
                        // nop and undefined opcodes
                     end
                  endcase
               end

               ST_VEC_WR: begin
                  // every word is data here and gets no command decode
                  wr.wr_vec  <= 1'b1;
                  wr.vec_idx <= vec_pos;
                  wr.value   <= rx_word.data.value;
                  vec_cnt    <= vec_cnt - 1'b1;
                  if (vec_cnt == 8'd1) begin
                     state <= ST_IDLE;
                  end
               end

               ST_VEC_RD: begin
                  if (opcode == spi_cmd_pkg::OP_INIT) begin
                     // init aborts the readout and loads no response
                     wr.init <= 1'b1;
                     state   <= ST_IDLE;
                     vec_cnt <= '0;
                  end else begin
                     tx_load <= 1'b1;
                     vec_cnt <= vec_cnt - 1'b1;
                     if (vec_cnt == 8'd1) begin
                        state <= ST_IDLE;
                     end
                  end
               end

               default: begin
                  state   <= ST_IDLE;
                  vec_cnt <= '0;
               end
            endcase
         end
      end
   end

endmodule

/* source/cmd_regs.sv */
`timescale 1ns/1ps

module cmd_regs #(
   parameter int VEC_LEN = 4
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  spi_cmd_pkg::reg_wr_t   wr,
   input  logic [7:0]             vec_rd_idx,
   output spi_cmd_pkg::reg_view_t view,
   output logic [23:0]            vec_rd_data,
   output logic [2:0]             leds
);

   logic [15:0] inv_q;
   logic [2:0]  leds_q;
   logic [23:0] vec_q [VEC_LEN];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         inv_q  <= '0;
         leds_q <= '0;
         for (int i = 0; i < VEC_LEN; i++) begin
            vec_q[i] <= '0;
         end
      end else if (wr.init) begin
         // init wins over any other strobe
         inv_q  <= '0;
         leds_q <= '0;
         for (int i = 0; i < VEC_LEN; i++) begin
            vec_q[i] <= '0;
         end
      end else begin
         if (wr.wr_inv) begin
            inv_q <= wr.value[15:0];
         end
         if (wr.wr_leds) begin
            leds_q <= wr.value[2:0];
         end
         // out of range index writes nothing
         for (int i = 0; i < VEC_LEN; i++) begin
            if (wr.wr_vec && wr.vec_idx == 8'(i)) begin
               vec_q[i] <= wr.value;
            end
         end
      end
   end

   // read mux, zero past the last entry
   always_comb begin
      vec_rd_data = '0;
      for (int i = 0; i < VEC_LEN; i++) begin
         if (vec_rd_idx == 8'(i)) begin
            vec_rd_data = vec_q[i];
         end
      end
   end

   assign view.inv_word = inv_q;
   assign view.leds     = leds_q;
   assign leds          = leds_q;

endmodule

/* source/spi_cmd_pkg.sv */
package spi_cmd_pkg;

   // bits per SPI frame
   localparam int WORD_BITS = 32;

   // command opcodes, undefined values act as NOP
   typedef enum logic [7:0] {
      OP_NOP     = 8'd0,
      OP_INIT    = 8'd1,
      OP_WR_INV  = 8'd2,
      OP_RD_INV  = 8'd3,
      OP_WR_LEDS = 8'd4,
      OP_RD_LEDS = 8'd5,
      OP_WR_VEC  = 8'd6,
      OP_RD_VEC  = 8'd7
   } opcode_e;

   // command word, opcode in the top byte
   typedef struct packed {
      opcode_e     opcode;
      logic [23:0] payload;
   } cmd_frame_t;

   // vector data word, top byte carries nothing
   typedef struct packed {
      logic [7:0]  unused;
      logic [23:0] value;
   } data_frame_t;

   // one received word, read as command or as data depending on engine state
   typedef union packed {
      cmd_frame_t  cmd;
      data_frame_t data;
   } rx_word_u;

   // write strobes from engine to register block
   typedef struct packed {
      logic        wr_inv;
      logic        wr_leds;
      logic        wr_vec;
      logic        init;
      logic [7:0]  vec_idx;
      logic [23:0] value;
   } reg_wr_t;

   // register contents seen by the engine
   typedef struct packed {
      logic [15:0] inv_word;
      logic [2:0]  leds;
   } reg_view_t;

endpackage

/* source/spi_cmd_top.sv */
`timescale 1ns/1ps

module spi_cmd_top #(
   parameter int VEC_LEN = 4
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       sck,
   input  logic       ss_n,
   input  logic       mosi,
   output logic       miso,
   output logic [2:0] leds
);

   logic                                rx_valid;
   spi_cmd_pkg::rx_word_u               rx_word;
   logic                                tx_load;
   logic [spi_cmd_pkg::WORD_BITS-1:0]   tx_word;
   spi_cmd_pkg::reg_wr_t                wr;
   spi_cmd_pkg::reg_view_t              view;
   logic [23:0]                         vec_rd_data;
   logic [7:0]                          vec_rd_idx;

   // pin side, frames in and out
   spi_slave u_slave (
      .clk      (clk),
      .arst_n   (arst_n),
      .sck      (sck),
      .ss_n     (ss_n),
      .mosi     (mosi),
      .tx_load  (tx_load),
      .tx_word  (tx_word),
      .miso     (miso),
      .rx_valid (rx_valid),
      .rx_word  (rx_word)
   );

   cmd_engine #(
      .VEC_LEN (VEC_LEN)
   ) u_engine (
      .clk         (clk),
      .arst_n      (arst_n),
      .rx_valid    (rx_valid),
      .rx_word     (rx_word),
      .view        (view),
      .vec_rd_data (vec_rd_data),
      .tx_load     (tx_load),
      .tx_word     (tx_word),
      .wr          (wr),
      .vec_rd_idx  (vec_rd_idx)
   );

   cmd_regs #(
      .VEC_LEN (VEC_LEN)
   ) u_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .wr          (wr),
      .vec_rd_idx  (vec_rd_idx),
      .view        (view),
      .vec_rd_data (vec_rd_data),
      .leds        (leds)
   );

endmodule

/* source/spi_slave.sv */
`timescale 1ns/1ps

module spi_slave (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                sck,
   input  logic                                ss_n,
   input  logic                                mosi,
   input  logic                                tx_load,
   input  logic [spi_cmd_pkg::WORD_BITS-1:0]   tx_word,
   output logic                                miso,
   output logic                                rx_valid,
   output spi_cmd_pkg::rx_word_u               rx_word
);

   localparam int W     = spi_cmd_pkg::WORD_BITS;
   localparam int CNT_W = $clog2(W);

   // pin order is {sck, ss_n, mosi}, slave select idles high
   localparam logic [2:0] PIN_IDLE = 3'b010;

   logic [2:0]       pin_meta;
   logic [2:0]       pin_sync;
   logic             sck_s;
   logic             ss_n_s;
   logic             mosi_s;
   logic             sck_q;
   logic             ss_n_q;
   logic             sck_rise;
   logic             sck_fall;
   logic             frame_start;

   logic [CNT_W-1:0] bit_cnt;
   logic [W-1:0]     rx_shift;
   logic [W-1:0]     tx_shift;
   logic [W-1:0]     tx_hold;
   logic             tx_pend;

   // two-flop synchronizers for all three pins
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pin_meta <= PIN_IDLE;
         pin_sync <= PIN_IDLE;
         sck_q    <= 1'b0;
         ss_n_q   <= 1'b1;
      end else begin
         pin_meta <= {sck, ss_n, mosi};
         pin_sync <= pin_meta;
         sck_q    <= sck_s;
         ss_n_q   <= ss_n_s;
      end
   end

   assign {sck_s, ss_n_s, mosi_s} = pin_sync;

   // edges in the clk domain
   assign sck_rise    = sck_s & ~sck_q;
   assign sck_fall    = ~sck_s & sck_q;
   assign frame_start = ss_n_q & ~ss_n_s;

   // bit counter, held at zero between frames
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (ss_n_s) begin
            bit_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            // 32nd bit completes the word
            if (bit_cnt == CNT_W'(W - 1)) begin
               rx_valid <= 1'b1;
            end
         end
      end
   end

   // mode 0, sample mosi on rising sck, msb first
   always_ff @(posedge clk) begin
      if (!ss_n_s && sck_rise) begin
         rx_shift <= {rx_shift[W-2:0], mosi_s};
      end
   end

   // shift register already holds the full word when rx_valid rises
   assign rx_word = rx_shift;

   // response word waiting for the next frame
   always_ff @(posedge clk) begin
      if (tx_load) begin
         tx_hold <= tx_word;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_pend  <= 1'b0;
         tx_shift <= '0;
      end else begin
         if (frame_start) begin
            // zero goes out if nothing was loaded since last frame
            tx_shift <= tx_pend ? tx_hold : '0;
            tx_pend  <= 1'b0;
         end else if (!ss_n_s && sck_fall) begin
            tx_shift <= {tx_shift[W-2:0], 1'b0};
         end
         if (tx_load) begin
            tx_pend <= 1'b1;
         end
      end
   end

   assign miso = tx_shift[W-1];

endmodule
